// ==== riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

    localparam int instr_w  = 32;
    localparam int opcode_w = 7;
    localparam int funct3_w = 3;
    localparam int funct7_w = 7;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [opcode_w-1:0] {
        opc_op        = 7'b0110011,
        opc_op_32     = 7'b0111011,
        opc_op_imm    = 7'b0010011,
        opc_op_imm_32 = 7'b0011011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_branch    = 7'b1100011,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_system    = 7'b1110011
    } opcode_e;

    // alu minor opcodes, shared by register and immediate forms
    localparam logic [funct3_w-1:0] f3_add_sub = 3'b000;
    localparam logic [funct3_w-1:0] f3_sll     = 3'b001;
    localparam logic [funct3_w-1:0] f3_slt     = 3'b010;
    localparam logic [funct3_w-1:0] f3_sltu    = 3'b011;
    localparam logic [funct3_w-1:0] f3_xor     = 3'b100;
    localparam logic [funct3_w-1:0] f3_srl_sra = 3'b101;
    localparam logic [funct3_w-1:0] f3_or      = 3'b110;
    localparam logic [funct3_w-1:0] f3_and     = 3'b111;

    // loads whose width field alone does not decide legality
    localparam logic [funct3_w-1:0] f3_lwu        = 3'b110;
    localparam logic [funct3_w-1:0] f3_load_rsvd  = 3'b111;

    localparam logic [funct3_w-1:0] f3_beq  = 3'b000;
    localparam logic [funct3_w-1:0] f3_bne  = 3'b001;
    localparam logic [funct3_w-1:0] f3_blt  = 3'b100;
    localparam logic [funct3_w-1:0] f3_bge  = 3'b101;
    localparam logic [funct3_w-1:0] f3_bltu = 3'b110;
    localparam logic [funct3_w-1:0] f3_bgeu = 3'b111;

    // ecall, ebreak and mret share f3_priv
    localparam logic [funct3_w-1:0] f3_priv   = 3'b000;
    localparam logic [funct3_w-1:0] f3_csrrw  = 3'b001;
    localparam logic [funct3_w-1:0] f3_csrrs  = 3'b010;
    localparam logic [funct3_w-1:0] f3_csrrc  = 3'b011;
    localparam logic [funct3_w-1:0] f3_csrrwi = 3'b101;
    localparam logic [funct3_w-1:0] f3_csrrsi = 3'b110;
    localparam logic [funct3_w-1:0] f3_csrrci = 3'b111;

    localparam logic [funct7_w-1:0] funct7_base = 7'b0000000;
    localparam logic [funct7_w-1:0] funct7_alt  = 7'b0100000;
    localparam logic [funct7_w-1:0] funct7_mret = 7'b0011000;

    typedef enum logic [3:0] {
        cls_op,
        cls_op32,
        cls_op_imm,
        cls_op_imm32,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_lui,
        cls_auipc,
        cls_system,
        cls_illegal
    } instr_class_e;

endpackage

`default_nettype wire

// ==== decode_ctrl_pkg.sv ====
`default_nettype none

package decode_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_jalr,
        alu_copy_b
    } alu_op_e;

    typedef enum logic [1:0] {
        a_rs1 = 2'd0,
        a_pc  = 2'd1,
        a_csr = 2'd2
    } a_src_e;

    typedef enum logic [1:0] {
        b_rs2  = 2'd0,
        b_imm  = 2'd1,
        b_rs1  = 2'd2,
        b_zimm = 2'd3
    } b_src_e;

    typedef enum logic [1:0] {
        wb_alu      = 2'd0,
        wb_mem      = 2'd1,
        wb_pc_plus4 = 2'd2,
        wb_csr      = 2'd3
    } wb_src_e;

    // branch senses test the alu result against zero
    typedef enum logic [2:0] {
        pc_plus4         = 3'd0,
        pc_br_on_zero    = 3'd1,
        pc_br_on_nonzero = 3'd2,
        pc_jal_target    = 3'd3,
        pc_jalr_result   = 3'd4,
        pc_csr_epc       = 3'd5
    } pc_src_e;

    typedef enum logic [1:0] {
        w_byte  = 2'd0,
        w_half  = 2'd1,
        w_word  = 2'd2,
        w_dword = 2'd3
    } width_e;

    typedef enum logic [1:0] {
        csr_alu_res = 2'd0,
        csr_rs1     = 2'd1,
        csr_zimm    = 2'd2,
        csr_zero    = 2'd3
    } csr_src_e;

    typedef enum logic [1:0] {
        trap_none  = 2'b00,
        trap_ecall = 2'b01,
        trap_mret  = 2'b11
    } trap_e;

    typedef struct packed {
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        wb_src_e  wb_src;
        a_src_e   alu_a_src;
        b_src_e   alu_b_src;
        logic     alu_b_neg;
        alu_op_e  alu_op;
        width_e   data_width;
        pc_src_e  pc_src;
        logic     csr_we;
        csr_src_e csr_src;
        trap_e    trap;
        logic     illegal;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== opcode_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder #(
    parameter int XLEN = 64
) (
    input  wire logic [riscv_isa_pkg::opcode_w-1:0] opcode,
    output riscv_isa_pkg::instr_class_e             cls,
    output decode_ctrl_pkg::ctrl_t                  base
);

    import riscv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    always_comb begin
        case (opcode_e'(opcode))
            opc_op:        cls = cls_op;
            opc_op_imm:    cls = cls_op_imm;
            opc_load:      cls = cls_load;
            opc_store:     cls = cls_store;
            opc_branch:    cls = cls_branch;
            opc_jal:       cls = cls_jal;
            opc_jalr:      cls = cls_jalr;
            opc_lui:       cls = cls_lui;
            opc_auipc:     cls = cls_auipc;
            opc_system:    cls = cls_system;
            // word forms only exist on rv64
            opc_op_32:     cls = (XLEN == 64) ? cls_op32 : cls_illegal;
            opc_op_imm_32: cls = (XLEN == 64) ? cls_op_imm32 : cls_illegal;
            default:       cls = cls_illegal;
        endcase
    end

    // class-wide fields, funct-dependent ones are filled in by the other decoders
    always_comb begin
        base = '0;

        base.mem_read  = (cls == cls_load);
        base.mem_write = (cls == cls_store);
        base.reg_write = cls inside {cls_op, cls_op32, cls_op_imm, cls_op_imm32, cls_load,
                                     cls_jal, cls_jalr, cls_lui, cls_auipc};

        if (cls inside {cls_op_imm, cls_op_imm32, cls_load, cls_store, cls_jalr,
                        cls_lui, cls_auipc}) begin
            base.alu_b_src = b_imm;
        end

        case (cls)
            cls_load: begin
                base.wb_src = wb_mem;
                base.alu_op = alu_add;
            end
            cls_store: begin
                base.alu_op = alu_add;
            end
            cls_jal: begin
                base.wb_src = wb_pc_plus4;
                base.pc_src = pc_jal_target;
                base.alu_op = alu_add;
            end
            cls_jalr: begin
                base.wb_src = wb_pc_plus4;
                base.pc_src = pc_jalr_result;
                base.alu_op = alu_jalr;
            end
            cls_lui: begin
                base.alu_op = alu_copy_b;
            end
            cls_auipc: begin
                base.alu_a_src = a_pc;
                base.alu_op    = alu_add;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== alu_op_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_op_decoder (
    input  wire riscv_isa_pkg::instr_class_e        cls,
    input  wire logic [riscv_isa_pkg::funct3_w-1:0] funct3,
    input  wire logic [riscv_isa_pkg::funct7_w-1:0] funct7,
    output decode_ctrl_pkg::alu_op_e                alu_op,
    output decode_ctrl_pkg::pc_src_e                br_sense,
    output logic                                    bad_funct
);

    import riscv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    logic is_alu;
    logic is_imm;
    logic is_word;
    logic f7_base;
    logic f7_alt;

    assign is_alu  = cls inside {cls_op, cls_op32, cls_op_imm, cls_op_imm32};
    assign is_imm  = cls inside {cls_op_imm, cls_op_imm32};
    assign is_word = cls inside {cls_op32, cls_op_imm32};

    // funct7[0] is shamt[5] on immediate shifts
    assign f7_base = is_imm ? (funct7[6:1] == funct7_base[6:1]) : (funct7 == funct7_base);
    assign f7_alt  = is_imm ? (funct7[6:1] == funct7_alt[6:1]) : (funct7 == funct7_alt);

    always_comb begin
        alu_op    = alu_add;
        br_sense  = pc_plus4;
        bad_funct = 1'b0;

        if (is_alu) begin
            case (funct3)
                f3_add_sub: begin
                    if (is_imm) begin
                        alu_op = alu_add;
                    end else if (f7_alt) begin
                        alu_op = alu_sub;
                    end else begin
                        alu_op    = alu_add;
                        bad_funct = !f7_base;
                    end
                end
                f3_sll: begin
                    alu_op    = alu_sll;
                    bad_funct = !(f7_base || f7_alt);
                end
                f3_srl_sra: begin
                    alu_op    = f7_alt ? alu_sra : alu_srl;
                    bad_funct = !(f7_base || f7_alt);
                end
                f3_slt:  alu_op = alu_slt;
                f3_sltu: alu_op = alu_sltu;
                f3_xor:  alu_op = alu_xor;
                f3_or:   alu_op = alu_or;
                default: alu_op = alu_and;
            endcase

            // word forms have no compare or logic operations
            if (is_word && !(funct3 inside {f3_add_sub, f3_sll, f3_srl_sra})) begin
                bad_funct = 1'b1;
            end
        end else if (cls == cls_branch) begin
            case (funct3)
                f3_beq:  {alu_op, br_sense} = {alu_sub, pc_br_on_zero};
                f3_bne:  {alu_op, br_sense} = {alu_sub, pc_br_on_nonzero};
                f3_blt:  {alu_op, br_sense} = {alu_slt, pc_br_on_nonzero};
                f3_bge:  {alu_op, br_sense} = {alu_slt, pc_br_on_zero};
                f3_bltu: {alu_op, br_sense} = {alu_sltu, pc_br_on_nonzero};
                f3_bgeu: {alu_op, br_sense} = {alu_sltu, pc_br_on_zero};
                default: bad_funct = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== access_width_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_width_decoder #(
    parameter int XLEN = 64
) (
    input  wire riscv_isa_pkg::instr_class_e        cls,
    input  wire logic [riscv_isa_pkg::funct3_w-1:0] funct3,
    output decode_ctrl_pkg::width_e                 data_width,
    output logic                                    bad_width
);

    import riscv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam bit dword_ok = (XLEN == 64);

    always_comb begin
        data_width = dword_ok ? w_dword : w_word;
        bad_width  = 1'b0;

        case (cls)
            cls_load: begin
                // unsigned loads share the width of their signed forms
                data_width = width_e'(funct3[1:0]);
                bad_width  = (funct3 == f3_load_rsvd) ||
                             (!dword_ok && (funct3[1:0] == 2'b11 || funct3 == f3_lwu));
            end
            cls_store: begin
                data_width = width_e'(funct3[1:0]);
                bad_width  = funct3[2] || (!dword_ok && funct3[1:0] == 2'b11);
            end
            cls_op32, cls_op_imm32: data_width = w_word;
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== system_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module system_decoder (
    input  wire riscv_isa_pkg::instr_class_e        cls,
    input  wire logic [riscv_isa_pkg::funct3_w-1:0] funct3,
    input  wire logic [riscv_isa_pkg::funct7_w-1:0] funct7,
    output decode_ctrl_pkg::ctrl_t                  sys,
    output logic                                    bad_sys
);

    import riscv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    always_comb begin
        sys     = '0;
        bad_sys = 1'b0;

        if (cls == cls_system) begin
            if (funct3 == f3_priv) begin
                // traps redirect the pc but leave the register file alone
                if (funct7 == funct7_mret) begin
                    sys.trap   = trap_mret;
                    sys.pc_src = pc_csr_epc;
                end else begin
                    sys.trap = trap_ecall;
                end
            end else begin
                sys.csr_we    = 1'b1;
                sys.reg_write = 1'b1;
                sys.wb_src    = wb_csr;
                // immediate forms take the zero-extended rs1 field as operand b
                sys.alu_b_src = funct3[2] ? b_zimm : b_rs1;

                case (funct3)
                    f3_csrrw, f3_csrrwi: begin
                        sys.alu_op    = alu_add;
                        sys.alu_a_src = a_rs1;
                        sys.csr_src   = csr_zimm;
                    end
                    f3_csrrs, f3_csrrsi: begin
                        sys.alu_op    = alu_or;
                        sys.alu_a_src = a_csr;
                        sys.csr_src   = csr_alu_res;
                    end
                    f3_csrrc, f3_csrrci: begin
                        sys.alu_op    = alu_and;
                        sys.alu_a_src = a_csr;
                        sys.alu_b_neg = 1'b1;
                        sys.csr_src   = csr_alu_res;
                    end
                    default: begin
                        bad_sys = 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int XLEN = 64
) (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                instr_valid,
    input  wire logic [riscv_isa_pkg::instr_w-1:0]   instr,
    output logic                                     ctrl_valid,
    output decode_ctrl_pkg::ctrl_t                   ctrl
);

    import riscv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    instr_class_e cls;
    ctrl_t        base;
    ctrl_t        sys;
    ctrl_t        ctrl_next;
    alu_op_e      alu_op;
    pc_src_e      br_sense;
    width_e       data_width;
    logic         bad_funct;
    logic         bad_width;
    logic         bad_sys;

    logic [opcode_w-1:0] opcode;
    logic [funct3_w-1:0] funct3;
    logic [funct7_w-1:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    opcode_decoder #(
        .XLEN (XLEN)
    ) i_opcode_decoder (
        .opcode (opcode),
        .cls    (cls),
        .base   (base)
    );

    alu_op_decoder i_alu_op_decoder (
        .cls       (cls),
        .funct3    (funct3),
        .funct7    (funct7),
        .alu_op    (alu_op),
        .br_sense  (br_sense),
        .bad_funct (bad_funct)
    );

    access_width_decoder #(
        .XLEN (XLEN)
    ) i_access_width_decoder (
        .cls        (cls),
        .funct3     (funct3),
        .data_width (data_width),
        .bad_width  (bad_width)
    );

    system_decoder i_system_decoder (
        .cls     (cls),
        .funct3  (funct3),
        .funct7  (funct7),
        .sys     (sys),
        .bad_sys (bad_sys)
    );

    always_comb begin
        ctrl_next = base;

        case (cls)
            cls_op, cls_op32, cls_op_imm, cls_op_imm32: begin
                ctrl_next.alu_op = alu_op;
            end
            cls_branch: begin
                ctrl_next.alu_op = alu_op;
                ctrl_next.pc_src = br_sense;
            end
            cls_system: begin
                ctrl_next = sys;
            end
            default: begin
            end
        endcase

        ctrl_next.data_width = data_width;

        // an illegal encoding must not enable anything downstream
        if (cls == cls_illegal || bad_funct || bad_width || bad_sys) begin
            ctrl_next         = '0;
            ctrl_next.illegal = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_valid <= 1'b0;
            ctrl       <= '0;
        end else begin
            ctrl_valid <= instr_valid;
            ctrl       <= ctrl_next;
        end
    end

endmodule

`default_nettype wire

// ==== tb_decode_model.svh ====
`ifndef tb_decode_model_svh
`define tb_decode_model_svh

// expected control bundle for one instruction word, built from the decode rules
function automatic ctrl_t predict_ctrl(input logic [31:0] word);
    ctrl_t      c;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       bad;
    logic       imm_form;
    logic       word_form;
    logic       f7_ok;
    logic       f7_sub;

    opc = word[6:0];
    f3  = word[14:12];
    f7  = word[31:25];
    bad = 1'b0;
    c   = '0;
    c.data_width = (XLEN == 64) ? w_dword : w_word;

    case (opc)
        opc_op, opc_op_32, opc_op_imm, opc_op_imm_32: begin
            imm_form  = (opc == opc_op_imm) || (opc == opc_op_imm_32);
            word_form = (opc == opc_op_32) || (opc == opc_op_imm_32);
            // shamt[5] sits in funct7[0] for immediate shifts
            if (imm_form) begin
                f7_sub = (f7[6:1] == funct7_alt[6:1]);
                f7_ok  = (f7[6:1] == funct7_base[6:1]) || f7_sub;
            end else begin
                f7_sub = (f7 == funct7_alt);
                f7_ok  = (f7 == funct7_base) || f7_sub;
            end
            c.reg_write = 1'b1;
            c.alu_b_src = imm_form ? b_imm : b_rs2;
            case (f3)
                3'b000: begin
                    c.alu_op = (!imm_form && f7_sub) ? alu_sub : alu_add;
                    bad      = !imm_form && !f7_ok;
                end
                3'b001: begin
                    c.alu_op = alu_sll;
                    bad      = !f7_ok;
                end
                3'b101: begin
                    c.alu_op = f7_sub ? alu_sra : alu_srl;
                    bad      = !f7_ok;
                end
                3'b010: c.alu_op = alu_slt;
                3'b011: c.alu_op = alu_sltu;
                3'b100: c.alu_op = alu_xor;
                3'b110: c.alu_op = alu_or;
                default: c.alu_op = alu_and;
            endcase
            if (word_form) begin
                c.data_width = w_word;
                if (XLEN != 64 || !(f3 inside {3'b000, 3'b001, 3'b101})) begin
                    bad = 1'b1;
                end
            end
        end
        opc_load: begin
            c.mem_read   = 1'b1;
            c.reg_write  = 1'b1;
            c.wb_src     = wb_mem;
            c.alu_b_src  = b_imm;
            c.alu_op     = alu_add;
            c.data_width = width_e'(f3[1:0]);
            bad = (f3 == 3'b111) || (XLEN != 64 && (f3[1:0] == 2'b11 || f3 == 3'b110));
        end
        opc_store: begin
            c.mem_write  = 1'b1;
            c.alu_b_src  = b_imm;
            c.alu_op     = alu_add;
            c.data_width = width_e'(f3[1:0]);
            bad = f3[2] || (XLEN != 64 && f3[1:0] == 2'b11);
        end
        opc_branch: begin
            case (f3)
                3'b000: {c.alu_op, c.pc_src} = {alu_sub, pc_br_on_zero};
                3'b001: {c.alu_op, c.pc_src} = {alu_sub, pc_br_on_nonzero};
                3'b100: {c.alu_op, c.pc_src} = {alu_slt, pc_br_on_nonzero};
                3'b101: {c.alu_op, c.pc_src} = {alu_slt, pc_br_on_zero};
                3'b110: {c.alu_op, c.pc_src} = {alu_sltu, pc_br_on_nonzero};
                3'b111: {c.alu_op, c.pc_src} = {alu_sltu, pc_br_on_zero};
                default: bad = 1'b1;
            endcase
        end
        opc_jal: begin
            c.reg_write = 1'b1;
            c.wb_src    = wb_pc_plus4;
            c.pc_src    = pc_jal_target;
            c.alu_op    = alu_add;
        end
        opc_jalr: begin
            c.reg_write = 1'b1;
            c.wb_src    = wb_pc_plus4;
            c.pc_src    = pc_jalr_result;
            c.alu_b_src = b_imm;
            c.alu_op    = alu_jalr;
        end
        opc_lui: begin
            c.reg_write = 1'b1;
            c.alu_b_src = b_imm;
            c.alu_op    = alu_copy_b;
        end
        opc_auipc: begin
            c.reg_write = 1'b1;
            c.alu_a_src = a_pc;
            c.alu_b_src = b_imm;
            c.alu_op    = alu_add;
        end
        opc_system: begin
            if (f3 == 3'b000) begin
                c.trap   = (f7 == funct7_mret) ? trap_mret : trap_ecall;
                c.pc_src = (f7 == funct7_mret) ? pc_csr_epc : pc_plus4;
            end else if (f3 == 3'b100) begin
                bad = 1'b1;
            end else begin
                c.csr_we    = 1'b1;
                c.reg_write = 1'b1;
                c.wb_src    = wb_csr;
                c.alu_b_src = f3[2] ? b_zimm : b_rs1;
                case (f3[1:0])
                    2'b01: {c.alu_op, c.alu_a_src, c.csr_src} = {alu_add, a_rs1, csr_zimm};
                    2'b10: {c.alu_op, c.alu_a_src, c.csr_src} = {alu_or, a_csr, csr_alu_res};
                    default: begin
                        {c.alu_op, c.alu_a_src, c.csr_src} = {alu_and, a_csr, csr_alu_res};
                        c.alu_b_neg = 1'b1;
                    end
                endcase
            end
        end
        default: bad = 1'b1;
    endcase

    if (bad) begin
        c         = '0;
        c.illegal = 1'b1;
    end
    return c;
endfunction

`endif

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    import riscv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam int XLEN       = 64;
    localparam int num_cycles = 3000;
    localparam int drain_max  = 20;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        ctrl_valid;
    ctrl_t       ctrl;

    integer      seed;
    int          num_sent;
    int          num_checked;
    int          wait_cycles;
    logic        prev_valid;
    logic [31:0] word;
    string       kind;
    ctrl_t       exp_q[$];
    string       name_q[$];

    `include "tb_decode_model.svh"

    decode_stage #(
        .XLEN (XLEN)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl_valid  (ctrl_valid),
        .ctrl        (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED: %s expected %h actual %h",
                                name, expected, actual));
        end
    endtask

    function automatic string opcode_kind(input logic [6:0] opc);
        case (opc)
            opc_op:        return "op";
            opc_op_32:     return "op_32";
            opc_op_imm:    return "op_imm";
            opc_op_imm_32: return "op_imm_32";
            opc_load:      return "load";
            opc_store:     return "store";
            opc_branch:    return "branch";
            opc_jal:       return "jal";
            opc_jalr:      return "jalr";
            opc_lui:       return "lui";
            opc_auipc:     return "auipc";
            opc_system:    return "system";
            default:       return "unknown opcode";
        endcase
    endfunction

    // legal opcode with random fields and funct7 biased toward the encodings that matter
    function automatic logic [31:0] random_instr();
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        case ($unsigned($random(seed)) % 12)
            0:  opc = opc_op;
            1:  opc = opc_op_32;
            2:  opc = opc_op_imm;
            3:  opc = opc_op_imm_32;
            4:  opc = opc_load;
            5:  opc = opc_store;
            6:  opc = opc_branch;
            7:  opc = opc_jal;
            8:  opc = opc_jalr;
            9:  opc = opc_lui;
            10: opc = opc_auipc;
            default: opc = opc_system;
        endcase
        case ($unsigned($random(seed)) % 4)
            0: f7 = funct7_base;
            1: f7 = funct7_alt;
            2: f7 = funct7_mret;
            default: f7 = 7'($random(seed));
        endcase
        if ($unsigned($random(seed)) % 4 == 0) begin
            f7[0] = ~f7[0];
        end
        f3 = 3'($random(seed));
        return {f7, 10'($random(seed)), f3, 5'($random(seed)), opc};
    endfunction

    // result checker samples outputs on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_value("ctrl_valid one cycle after instr_valid",
                        {31'b0, prev_valid}, {31'b0, ctrl_valid});
            if (ctrl_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("ctrl_valid was high with no instruction in flight");
                end
                check_value(name_q.pop_front(), exp_q.pop_front(), ctrl);
                num_checked++;
            end
        end
        prev_valid = instr_valid;
    end

    initial begin
        seed        = 99475;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        prev_valid  = 1'b0;
        num_sent    = 0;
        num_checked = 0;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // idle gap so ctrl_valid is seen low before the first strobe
        repeat (4) @(posedge clk);

        for (int n = 0; n < num_cycles; n++) begin
            @(posedge clk);
            if ($unsigned($random(seed)) % 4 == 0) begin
                instr_valid <= 1'b0;
                instr       <= $random(seed);
            end else begin
                if ($unsigned($random(seed)) % 8 == 0) begin
                    word = $random(seed);
                    kind = "random word";
                end else begin
                    word = random_instr();
                    kind = opcode_kind(word[6:0]);
                end
                instr_valid <= 1'b1;
                instr       <= word;
                exp_q.push_back(predict_ctrl(word));
                name_q.push_back($sformatf("%s %h", kind, word));
                num_sent++;
            end
        end

        @(posedge clk);
        instr_valid <= 1'b0;

        wait_cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > drain_max) begin
                abort_run("timed out waiting for the remaining decode results");
            end
        end
        repeat (2) @(posedge clk);

        if (num_checked == num_sent && num_sent > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run($sformatf("sent %0d instructions but checked %0d results",
                                num_sent, num_checked));
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
riscv_isa_pkg.sv
decode_ctrl_pkg.sv
opcode_decoder.sv
alu_op_decoder.sv
access_width_decoder.sv
system_decoder.sv
decode_stage.sv
tb_decode_stage.sv
